/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module uart_tb -f filelist.f

run: compile
	./obj_dir/Vuart_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_tx_queue.sv
rtl/uart_rx_queue.sv
rtl/uart_top.sv
verification/uart_tb.sv

/* rtl/uart_fifo.sv */
`default_nettype none

module uart_fifo import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4               // entries, power of two
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_push,
    input  wire uart_byte_t i_data,
    input  wire             i_pop,
    output uart_byte_t      o_data,            // head entry, valid when not empty
    output logic            o_empty,
    output logic            o_full
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W + 1)'(FIFO_DEPTH);

    uart_byte_t        mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;                 // wraps with the power-of-two depth
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;                  // occupancy, 0..depth

    logic do_push;
    logic do_pop;

    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);  // full is fine if one leaves
    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == FULL_CNT);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // none, or push and pop together
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_push && o_full) |-> i_pop);

    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> !o_empty);

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;     // one data byte, host or serial side

    typedef logic [3:0] uart_bit_idx_t;  // bit position in a frame, 0..8

    typedef enum logic [2:0] {
        TX_IDLE,    // line high, waiting for a start request
        TX_START,   // start bit low
        TX_DATA,    // eight data bits, lsb first
        TX_STOP,    // stop bit high
        TX_DONE     // one cycle end-of-frame marker
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,    // hunting for a falling edge
        RX_START,   // recheck line low at half a bit
        RX_DATA,    // mid-bit sampling of data bits
        RX_STOP     // stop bit check
    } uart_rx_state_t;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int TICKS_PER_BIT = 16           // clock cycles per serial bit
) (
    input  wire        i_clk,
    input  wire        i_rst,
    input  wire        i_din,                  // async serial input
    output logic       o_valid,                // good frame, one cycle
    output uart_byte_t o_data,                 // held from last data bit
    output logic       o_frame_err             // low stop bit, one cycle
);

    localparam int TICK_W = $clog2(TICKS_PER_BIT);

    uart_rx_state_t    state;
    uart_byte_t        shift_q;                // msb-in, lands lsb first
    uart_bit_idx_t     bit_cnt;                // data bits sampled
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        din_sync;               // two sync flops plus history

    logic din_s;
    logic fall;
    logic tick_half;
    logic tick_full;

    assign din_s     = din_sync[1];
    assign fall      = din_sync[2] && !din_s;  // high to low on synced line
    assign tick_half = (tick_cnt == TICK_W'(TICKS_PER_BIT / 2 - 1));
    assign tick_full = (tick_cnt == TICK_W'(TICKS_PER_BIT - 1));
    assign o_data    = shift_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            din_sync    <= '1;                 // line idles high
            state       <= RX_IDLE;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            din_sync    <= {din_sync[1:0], i_din};
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
            tick_cnt    <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (fall)
                        state <= RX_START;
                end
                RX_START: begin
                    if (tick_half) begin       // middle of start bit
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= din_s ? RX_IDLE : RX_DATA;  // glitch means false start
                    end
                end
                RX_DATA: begin
                    if (tick_full) begin       // middle of data bit
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == uart_bit_idx_t'(7))
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (tick_full) begin       // middle of stop bit
                        tick_cnt    <= '0;
                        o_valid     <= din_s;
                        o_frame_err <= !din_s;
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && tick_full)
            shift_q <= {din_s, shift_q[7:1]};
    end

    // only eight data bits are ever sampled in a frame
    a_data_bits_range: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == RX_DATA) |-> (bit_cnt <= uart_bit_idx_t'(7)));

endmodule

`default_nettype wire

/* rtl/uart_rx_queue.sv */
`default_nettype none

module uart_rx_queue import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_rx_valid,        // good byte from deserializer
    input  wire uart_byte_t i_rx_data,
    input  wire             i_credit,          // host grants room for one byte
    output logic            o_valid,           // delivery, one byte per credit
    output uart_byte_t      o_data,
    output logic            o_overrun          // byte dropped at full fifo
);

    localparam int CRED_W = $clog2(FIFO_DEPTH) + 6;  // room for many outstanding grants

    logic [CRED_W-1:0] credits;                // granted, not yet used
    logic              fifo_empty;
    logic              fifo_full;
    logic              push;

    assign push    = i_rx_valid && !fifo_full;
    assign o_valid = (credits != '0) && !fifo_empty;

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_push (push),
        .i_data (i_rx_data),
        .i_pop  (o_valid),                     // delivered byte leaves
        .o_data (o_data),
        .o_empty(fifo_empty),
        .o_full (fifo_full)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            credits   <= '0;
            o_overrun <= 1'b0;
        end else begin
            o_overrun <= i_rx_valid && fifo_full;
            case ({i_credit, o_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;   // grant and delivery cancel
            endcase
        end
    end

    a_credit_no_wrap: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_credit && (&credits)) |-> o_valid);

endmodule

`default_nettype wire

/* rtl/uart_top.sv */
`default_nettype none

module uart_top import uart_pkg::*; #(
    parameter int TICKS_PER_BIT = 16,          // clocks per serial bit
    parameter int FIFO_DEPTH    = 4            // per-fifo entries, power of two
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_tx_valid,
    input  wire uart_byte_t i_tx_data,
    output logic            o_tx_credit,
    output logic            o_tx,
    input  wire             i_rx,
    input  wire             i_rx_credit,
    output logic            o_rx_valid,
    output uart_byte_t      o_rx_data,
    output logic            o_rx_overrun,
    output logic            o_rx_frame_err
);

    logic       tx_start;                      // queue to serializer
    uart_byte_t tx_byte;
    logic       tx_busy;
    logic       rx_valid;                      // deserializer to queue
    uart_byte_t rx_byte;

    uart_tx_queue #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tx_queue (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (i_tx_valid),
        .i_data    (i_tx_data),
        .i_tx_busy (tx_busy),
        .o_tx_start(tx_start),
        .o_tx_data (tx_byte),
        .o_credit  (o_tx_credit)
    );

    uart_tx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_tx (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_start(tx_start),
        .i_data (tx_byte),
        .o_done (),                            // frame end not needed here
        .o_busy (tx_busy),
        .o_dout (o_tx)
    );

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_rx (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_din      (i_rx),
        .o_valid    (rx_valid),
        .o_data     (rx_byte),
        .o_frame_err(o_rx_frame_err)
    );

    uart_rx_queue #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_queue (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rx_valid(rx_valid),
        .i_rx_data (rx_byte),
        .i_credit  (i_rx_credit),
        .o_valid   (o_rx_valid),
        .o_data    (o_rx_data),
        .o_overrun (o_rx_overrun)
    );

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int TICKS_PER_BIT = 16           // clock cycles per serial bit
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_start,           // launch, only seen in idle
    input  wire uart_byte_t i_data,            // latched with i_start
    output logic            o_done,            // high in the done cycle
    output logic            o_busy,            // start through done
    output logic            o_dout             // serial line
);

    localparam int TICK_W = $clog2(TICKS_PER_BIT);

    uart_tx_state_t    state;
    uart_tx_state_t    state_nxt;
    uart_byte_t        shift_q;                // outgoing bits, lsb on the line
    uart_bit_idx_t     bit_cnt;                // data bits already sent
    logic [TICK_W-1:0] tick_cnt;               // position inside current bit

    logic tick_last;
    logic bits_done;
    logic tick_run;

    assign tick_last = (tick_cnt == TICK_W'(TICKS_PER_BIT - 1));
    assign bits_done = bit_cnt[3];             // set after the eighth bit

    // counter stalls in the one-cycle exit from data, so stop gets a full bit
    assign tick_run = (state == TX_START) || (state == TX_STOP) ||
                      (state == TX_DATA && !bits_done);

    always_comb begin
        state_nxt = state;
        o_done    = 1'b0;
        o_busy    = 1'b1;
        o_dout    = 1'b1;                      // idle and stop level
        case (state)
            TX_IDLE: begin
                o_busy = 1'b0;
                if (i_start)
                    state_nxt = TX_START;
            end
            TX_START: begin
                o_dout = 1'b0;                 // start bit
                if (tick_last)
                    state_nxt = TX_DATA;
            end
            TX_DATA: begin
                o_dout = bits_done ? 1'b1 : shift_q[0];
                if (bits_done)
                    state_nxt = TX_STOP;       // extra exit cycle, line already high
            end
            TX_STOP: begin
                if (tick_last)
                    state_nxt = TX_DONE;
            end
            TX_DONE: begin
                o_done    = 1'b1;
                state_nxt = TX_IDLE;
            end
            default: begin
                o_busy    = 1'b0;
                state_nxt = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (tick_run)
                tick_cnt <= tick_last ? '0 : tick_cnt + 1'b1;
            if (state == TX_IDLE && i_start)
                bit_cnt <= '0;                 // fresh frame
            else if (state == TX_DATA && !bits_done && tick_last)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start)
            shift_q <= i_data;                 // byte taken on the start cycle
        else if (state == TX_DATA && !bits_done && tick_last)
            shift_q <= shift_q >> 1;           // next bit to lsb
    end

    // bit counter stops at eight, never runs past the frame
    a_bit_cnt_range: assert property (@(posedge i_clk) disable iff (i_rst)
        bit_cnt <= uart_bit_idx_t'(8));

endmodule

`default_nettype wire

/* rtl/uart_tx_queue.sv */
`default_nettype none

module uart_tx_queue import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4               // also the host's initial credits
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_valid,           // host byte, costs one credit
    input  wire uart_byte_t i_data,
    input  wire             i_tx_busy,         // serializer in a frame
    output logic            o_tx_start,
    output uart_byte_t      o_tx_data,
    output logic            o_credit           // one credit back per launched byte
);

    logic fifo_empty;
    logic launched;                            // start issued, busy not seen yet

    assign o_tx_start = !fifo_empty && !i_tx_busy && !launched;
    assign o_credit   = o_tx_start;            // byte leaves the fifo here

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_push (i_valid),
        .i_data (i_data),
        .i_pop  (o_tx_start),                  // pop with the launch
        .o_data (o_tx_data),                   // head goes straight to serializer
        .o_empty(fifo_empty),
        .o_full ()
    );

    always_ff @(posedge i_clk) begin
        if (i_rst)
            launched <= 1'b0;
        else if (o_tx_start)
            launched <= 1'b1;
        else if (i_tx_busy)
            launched <= 1'b0;                  // serializer has it
    end

    // serializer must take every launch on the next edge
    a_start_taken: assert property (@(posedge i_clk) disable iff (i_rst)
        o_tx_start |=> i_tx_busy);

endmodule

`default_nettype wire

/* verification/uart_tb.sv */
`default_nettype none

module uart_tb import uart_pkg::*; ();

    localparam int TICKS      = 8;                  // clocks per serial bit
    localparam int DEPTH      = 4;                  // fifo entries, initial tx credits
    localparam int TIMEOUT    = 4000;               // cycles allowed per wait
    localparam int LOOP_BYTES = 20;

    logic       clk;
    logic       rst;
    logic       tx_valid;
    uart_byte_t tx_data;
    logic       tx_credit;
    logic       tx_line;
    logic       rx_line;
    logic       rx_credit;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_overrun;
    logic       rx_frame_err;

    logic       manual_mode;                        // i_rx from hand-built frame
    logic       manual_rx;
    logic       hold_rx;                            // phase with no receive credits

    integer     seed = 32'h2c3d587c;
    uart_byte_t frame_exp_q[$];                     // bytes still to show up on o_tx
    uart_byte_t rx_exp_q[$];                        // bytes still to be delivered
    int         tx_credits;                         // host view of transmit credits
    int         credit_pulses  = 0;
    int         bytes_sent     = 0;
    int         delivered      = 0;
    int         overruns       = 0;
    int         frame_errs     = 0;
    int         mismatch_count = 0;
    int         check_count    = 0;
    int         timeout_count  = 0;

    assign rx_line = manual_mode ? manual_rx : tx_line;  // loopback by default

    uart_top #(
        .TICKS_PER_BIT(TICKS),
        .FIFO_DEPTH   (DEPTH)
    ) UUT (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_tx_valid    (tx_valid),
        .i_tx_data     (tx_data),
        .o_tx_credit   (tx_credit),
        .o_tx          (tx_line),
        .i_rx          (rx_line),
        .i_rx_credit   (rx_credit),
        .o_rx_valid    (rx_valid),
        .o_rx_data     (rx_data),
        .o_rx_overrun  (rx_overrun),
        .o_rx_frame_err(rx_frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic note_mismatch(input string sig, input int got, input int exp);
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, sig, got, exp);
    endtask

    task automatic note_failure(input string what);
        check_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("TIMEOUT at %0t: gave up waiting for %s", $time, what);
    endtask

    // one byte from the host, only while a credit is held
    task automatic send_byte(input uart_byte_t b);
        int waited;
        waited = 0;
        while (tx_credits == 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_credits == 0) begin
            note_timeout("a transmit credit");
        end else begin
            tx_valid = 1'b1;
            tx_data  = b;
            frame_exp_q.push_back(b);
            rx_exp_q.push_back(b);
            bytes_sent++;
            @(negedge clk);
            tx_valid = 1'b0;
        end
    endtask

    task automatic grant_rx_credits(input int n);
        rx_credit = 1'b1;                           // one grant per cycle
        repeat (n) @(negedge clk);
        rx_credit = 1'b0;
    endtask

    task automatic wait_rx_drained(input string what);
        int waited;
        waited = 0;
        while (rx_exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_exp_q.size() != 0)
            note_timeout(what);
    endtask

    // 8N1 frame whose stop bit is held low
    task automatic send_bad_frame(input uart_byte_t b);
        manual_rx = 1'b0;                           // start bit
        repeat (TICKS) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            manual_rx = b[k];                       // lsb first
            repeat (TICKS) @(negedge clk);
        end
        manual_rx = 1'b0;                           // bad stop bit
        repeat (TICKS) @(negedge clk);
        manual_rx = 1'b1;
    endtask

    always @(posedge clk) begin : host_monitor
        uart_byte_t exp;
        if (rst) begin
            tx_credits = DEPTH;
        end else begin
            if (tx_valid)
                tx_credits--;
            if (tx_credit) begin
                tx_credits++;
                credit_pulses++;
            end
            assert (tx_credits >= 0) else note_failure("byte sent without a transmit credit");
            assert (tx_credits <= DEPTH) else note_failure("more credits returned than spent");
            if (rx_overrun)
                overruns++;
            if (rx_frame_err)
                frame_errs++;
            if (rx_valid) begin
                delivered++;
                assert (!hold_rx) else note_failure("byte delivered with no receive credit");
                assert (rx_exp_q.size() != 0) else note_failure("byte delivered, none expected");
                if (rx_exp_q.size() != 0) begin
                    exp = rx_exp_q.pop_front();
                    assert (rx_data == exp)
                        else note_mismatch("o_rx_data", int'(rx_data), int'(exp));
                end
            end
        end
    end

    // samples o_tx at mid-bit from each falling edge
    initial begin : frame_monitor
        uart_byte_t got;
        uart_byte_t exp;
        logic       line_prev;
        got       = '0;
        line_prev = 1'b1;
        forever begin
            @(posedge clk);
            if (!rst && line_prev && !tx_line) begin
                repeat (TICKS + TICKS / 2) @(posedge clk);  // middle of bit 0
                for (int k = 0; k < 8; k++) begin
                    got[k] = tx_line;
                    repeat (TICKS) @(posedge clk);
                end
                assert (tx_line === 1'b1) else note_mismatch("o_tx stop bit", int'(tx_line), 1);
                assert (frame_exp_q.size() != 0) else note_failure("frame on o_tx, none sent");
                if (frame_exp_q.size() != 0) begin
                    exp = frame_exp_q.pop_front();
                    assert (got == exp) else note_mismatch("o_tx data bits", int'(got), int'(exp));
                end
            end
            line_prev = tx_line;
        end
    end

    initial begin : main
        int waited;
        int base;
        rst         = 1'b1;
        tx_valid    = 1'b0;
        tx_data     = '0;
        rx_credit   = 1'b0;
        manual_mode = 1'b0;
        manual_rx   = 1'b1;                         // idle line level
        hold_rx     = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        repeat (3 * TICKS) begin                    // quiet after reset
            @(negedge clk);
            assert (tx_line === 1'b1) else note_failure("o_tx not high after reset");
            assert (tx_credit === 1'b0) else note_failure("o_tx_credit active after reset");
            assert (rx_valid === 1'b0) else note_failure("o_rx_valid active after reset");
            assert (rx_overrun === 1'b0) else note_failure("o_rx_overrun active after reset");
            assert (rx_frame_err === 1'b0) else note_failure("o_rx_frame_err active after reset");
        end

        grant_rx_credits(LOOP_BYTES);               // room for every loopback byte
        for (int n = 0; n < LOOP_BYTES; n++)
            send_byte(uart_byte_t'($random(seed)));
        wait_rx_drained("loopback bytes");
        assert (delivered == LOOP_BYTES) else note_mismatch("delivered", delivered, LOOP_BYTES);
        assert (credit_pulses == bytes_sent)
            else note_mismatch("o_tx_credit pulses", credit_pulses, bytes_sent);
        assert (tx_credits == DEPTH) else note_mismatch("host credits", tx_credits, DEPTH);

        hold_rx = 1'b1;                             // receive fifo fills up
        base    = delivered;
        for (int n = 0; n <= DEPTH; n++)
            send_byte(uart_byte_t'($random(seed)));
        waited = 0;
        while (overruns == 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (overruns == 0)
            note_timeout("o_rx_overrun on a full receive fifo");
        assert (rx_exp_q.size() == DEPTH + 1)
            else note_mismatch("pending bytes", rx_exp_q.size(), DEPTH + 1);
        if (rx_exp_q.size() != 0)
            void'(rx_exp_q.pop_back());             // last byte was dropped
        hold_rx = 1'b0;
        grant_rx_credits(DEPTH);
        wait_rx_drained("bytes held in the receive fifo");
        repeat (4 * TICKS) @(negedge clk);          // any extra delivery shows here
        assert (delivered - base == DEPTH) else note_mismatch("held bytes", delivered - base, DEPTH);
        assert (overruns == 1) else note_mismatch("o_rx_overrun pulses", overruns, 1);

        grant_rx_credits(1);                        // a wrong delivery could surface
        manual_mode = 1'b1;
        send_bad_frame(uart_byte_t'($random(seed)));
        waited = 0;
        while (frame_errs == 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (frame_errs == 0)
            note_timeout("o_rx_frame_err on a low stop bit");
        repeat (2 * TICKS) @(negedge clk);
        assert (frame_errs == 1) else note_mismatch("o_rx_frame_err pulses", frame_errs, 1);
        manual_mode = 1'b0;

        assert (frame_exp_q.size() == 0) else note_failure("sent bytes never framed on o_tx");
        $display("checks done: %0d mismatches, %0d other errors, %0d timeouts",
                 mismatch_count, check_count, timeout_count);
        if (mismatch_count + check_count + timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
